//--- logic/wb_pkg.sv
package wb_pkg;

    // *************************************************************************
    // line and beat geometry.
    // *************************************************************************
    localparam int PADDR_W     = 32;
    localparam int LINE_BYTES  = 32;
    localparam int BEAT_W      = 64;
    localparam int BEAT_BYTES  = BEAT_W / 8;
    localparam int BEATS       = LINE_BYTES / BEAT_BYTES;    // 4 beats per line.
    localparam int LINE_OFS_W  = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_W = PADDR_W - LINE_OFS_W;
    localparam int BEAT_IDX_W  = $clog2(BEATS);
    localparam int LINE_W      = BEATS * BEAT_W;

    // *************************************************************************
    // vector types.
    // *************************************************************************
    typedef logic [PADDR_W-1:0] paddr_t;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;    // address without offset.

    typedef logic [BEAT_W-1:0] beat_t;

    typedef logic [LINE_W-1:0] line_t;    // beat 0 in the low bits.

    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

endpackage

//--- logic/wb_fill_if.sv
interface wb_fill_if #(
    parameter int ENTRIES = 4
);
    import wb_pkg::*;

    localparam int SLOT_W = $clog2(ENTRIES);

    logic              ins_en;      // one cycle per dirty line.
    line_addr_t        ins_addr;
    line_t             ins_data;
    logic [SLOT_W-1:0] ins_slot;    // slot the next line lands in.
    logic              full;

    modport capture (output ins_en, ins_addr, ins_data, input full);
    modport queue (input ins_en, ins_addr, ins_data, output full, ins_slot);

endinterface

//--- logic/wb_drain_if.sv
interface wb_drain_if;
    import wb_pkg::*;

    // drain_valid is a level, addr and data stay put until retire.
    logic       drain_valid;
    line_addr_t drain_addr;
    line_t      drain_data;
    logic       retire;    // one-cycle pulse, frees the presented entry.

    modport queue (
        output drain_valid, drain_addr, drain_data,
        input  retire
    );

    modport writer (
        input  drain_valid, drain_addr, drain_data,
        output retire
    );

endinterface

//--- logic/victim_capture.sv
module victim_capture (
    input  logic           clk,
    input  logic           rst,
    input  logic           evict_valid,
    input  wb_pkg::paddr_t evict_addr,
    input  logic           evict_dirty,
    input  wb_pkg::beat_t  evict_data,
    output logic           evict_ready,
    wb_fill_if.capture     fill
);
    import wb_pkg::*;

    beat_idx_t  beat_cnt;
    line_t      line_buf;
    line_addr_t line_addr;
    logic       dirty_q;
    logic       pending;
    logic       line_dirty;
    logic       last_beat;
    logic       beat_acc;

    // beat 0 carries the dirty flag itself, later beats use the latched copy.
    assign line_dirty = (beat_cnt == '0) ? evict_dirty : dirty_q;
    assign last_beat  = (beat_cnt == beat_idx_t'(BEATS - 1));

    // a dirty last beat waits for a free slot, so the line never needs parking.
    assign evict_ready = !pending && !(last_beat && line_dirty && fill.full);
    assign beat_acc    = evict_valid && evict_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
            dirty_q  <= 1'b0;
            pending  <= 1'b0;
        end else begin
            if (beat_acc) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                if (beat_cnt == '0) begin
                    dirty_q <= evict_dirty;
                end
                if (last_beat && line_dirty) begin
                    pending <= 1'b1;    // clean lines just fall away.
                end
            end
            if (fill.ins_en) begin
                pending <= 1'b0;
            end
        end
    end

    // line assembly.
    always_ff @(posedge clk) begin
        if (beat_acc) begin
            line_buf[beat_cnt*BEAT_W +: BEAT_W] <= evict_data;
            if (beat_cnt == '0) begin
                line_addr <= evict_addr[PADDR_W-1:LINE_OFS_W];
            end
        end
    end

    assign fill.ins_en   = pending && !fill.full;
    assign fill.ins_addr = line_addr;
    assign fill.ins_data = line_buf;

endmodule

//--- logic/replace_queue.sv
module replace_queue #(
    parameter int ENTRIES = 4
) (
    input  logic           clk,
    input  logic           rst,
    wb_fill_if.queue       fill,
    wb_drain_if.queue      drain,
    input  wb_pkg::paddr_t lookup_addr,
    output logic           lookup_hit
);
    import wb_pkg::*;

    localparam int SLOT_W = $clog2(ENTRIES);

    line_addr_t         addr_q [ENTRIES];
    line_t              data_q [ENTRIES];
    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] prior_q;
    logic [ENTRIES-1:0] valid_nxt;
    logic [ENTRIES-1:0] ins_mask;
    logic [ENTRIES-1:0] ret_mask;
    logic [ENTRIES-1:0] hit_vec;
    logic [ENTRIES-1:0] prior_valid;
    logic [SLOT_W-1:0]  free_idx;
    logic [SLOT_W-1:0]  valid_idx;
    logic [SLOT_W-1:0]  prior_idx;
    logic [SLOT_W-1:0]  sel_idx;
    logic [SLOT_W-1:0]  head_q;
    logic               full_q;
    logic               drain_valid_q;
    line_addr_t         lookup_line;

    // index of the lowest set bit, zero when none is set.
    function automatic logic [SLOT_W-1:0] lowest_set(input logic [ENTRIES-1:0] vec);
        logic [SLOT_W-1:0] idx;
        idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = SLOT_W'(i);
            end
        end
        return idx;
    endfunction

    // *************************************************************************
    // slot bookkeeping.
    // *************************************************************************
    assign free_idx      = lowest_set(~valid_q);
    assign fill.ins_slot = free_idx;
    assign fill.full     = full_q;

    always_comb begin
        ins_mask = '0;
        ret_mask = '0;
        if (fill.ins_en) begin
            ins_mask[fill.ins_slot] = 1'b1;
        end
        if (drain.retire) begin
            ret_mask[head_q] = 1'b1;
        end
        valid_nxt = (valid_q | ins_mask) & ~ret_mask;
    end

    always_ff @(posedge clk) begin
        if (fill.ins_en) begin
            addr_q[fill.ins_slot] <= fill.ins_addr;
            data_q[fill.ins_slot] <= fill.ins_data;
        end
    end

    // *************************************************************************
    // lookup against pending lines.
    // *************************************************************************
    assign lookup_line = lookup_addr[PADDR_W-1:LINE_OFS_W];

    for (genvar i = 0; i < ENTRIES; i++) begin : g_hit
        assign hit_vec[i] = valid_q[i] && (addr_q[i] == lookup_line);
    end

    // *************************************************************************
    // drain selection.
    // *************************************************************************
    assign prior_valid = valid_q & prior_q;
    assign prior_idx   = lowest_set(prior_valid);
    assign valid_idx   = lowest_set(valid_q);
    assign sel_idx     = (|prior_valid) ? prior_idx : valid_idx;    // promoted lines first.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q       <= '0;
            prior_q       <= '0;
            full_q        <= 1'b0;
            lookup_hit    <= 1'b0;
            drain_valid_q <= 1'b0;
            head_q        <= '0;
        end else begin
            valid_q    <= valid_nxt;
            full_q     <= &valid_nxt;
            lookup_hit <= |hit_vec;
            prior_q    <= (prior_q | hit_vec) & ~ret_mask;    // retire wins over a hit.
            if (drain.retire) begin
                drain_valid_q <= 1'b0;
            end else if (!drain_valid_q && (|valid_q)) begin
                drain_valid_q <= 1'b1;
                head_q        <= sel_idx;
            end
        end
    end

    // the head slot is never rewritten while it is valid.
    assign drain.drain_valid = drain_valid_q;
    assign drain.drain_addr  = addr_q[head_q];
    assign drain.drain_data  = data_q[head_q];

endmodule

//--- logic/axi_wb_writer.sv
module axi_wb_writer (
    input  logic           clk,
    input  logic           rst,
    wb_drain_if.writer     drain,
    output logic           aw_valid,
    output wb_pkg::paddr_t aw_addr,
    output logic [7:0]     aw_len,
    input  logic           aw_ready,
    output logic           w_valid,
    output wb_pkg::beat_t  w_data,
    output logic           w_last,
    input  logic           w_ready,
    input  logic           b_valid,
    output logic           b_ready
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ADDRESS,
        WRITE,
        WAIT_B
    } wb_state_e;

    wb_state_e state;
    beat_idx_t beat_cnt;
    logic      retire_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            w_last   <= 1'b0;
            beat_cnt <= '0;
            retire_q <= 1'b0;
        end else begin
            retire_q <= 1'b0;
            case (state)
                IDLE: begin
                    // drain_valid is still up in the cycle of the retire pulse.
                    if (drain.drain_valid && !retire_q) begin
                        aw_valid <= 1'b1;
                        state    <= ADDRESS;
                    end
                end
                ADDRESS: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b1;
                        w_last   <= (BEATS == 1);
                        beat_cnt <= '0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    if (w_ready) begin
                        if (w_last) begin
                            w_valid <= 1'b0;
                            w_last  <= 1'b0;
                            state   <= WAIT_B;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            w_last   <= (beat_cnt == beat_idx_t'(BEATS - 2));
                        end
                    end
                end
                WAIT_B: begin
                    if (b_valid) begin
                        retire_q <= 1'b1;
                        state    <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // *************************************************************************
    // channel outputs.
    // *************************************************************************
    assign aw_addr = {drain.drain_addr, {LINE_OFS_W{1'b0}}};    // line aligned.
    assign aw_len  = 8'(BEATS - 1);

    assign w_data = drain.drain_data[beat_cnt*BEAT_W +: BEAT_W];

    assign b_ready = 1'b1;

    assign drain.retire = retire_q;

endmodule

//--- logic/wb_top.sv
module wb_top #(
    parameter int ENTRIES = 4
) (
    input  logic           clk,
    input  logic           rst,

    // eviction beats from the cache.
    input  logic           evict_valid,
    output logic           evict_ready,
    input  wb_pkg::paddr_t evict_addr,
    input  logic           evict_dirty,
    input  wb_pkg::beat_t  evict_data,

    // store and refill address check.
    input  wb_pkg::paddr_t lookup_addr,
    output logic           lookup_hit,
    output logic           queue_full,

    // AXI write address.
    output logic           aw_valid,
    input  logic           aw_ready,
    output wb_pkg::paddr_t aw_addr,
    output logic [7:0]     aw_len,

    // AXI write data.
    output logic           w_valid,
    input  logic           w_ready,
    output wb_pkg::beat_t  w_data,
    output logic           w_last,

    // AXI write response.
    input  logic           b_valid,
    output logic           b_ready
);

    wb_fill_if #(.ENTRIES(ENTRIES)) fill ();
    wb_drain_if drain ();

    victim_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .evict_valid (evict_valid),
        .evict_addr  (evict_addr),
        .evict_dirty (evict_dirty),
        .evict_data  (evict_data),
        .evict_ready (evict_ready),
        .fill        (fill.capture)
    );

    replace_queue #(.ENTRIES(ENTRIES)) u_queue (
        .clk         (clk),
        .rst         (rst),
        .fill        (fill.queue),
        .drain       (drain.queue),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit)
    );

    axi_wb_writer u_writer (
        .clk      (clk),
        .rst      (rst),
        .drain    (drain.writer),
        .aw_valid (aw_valid),
        .aw_addr  (aw_addr),
        .aw_len   (aw_len),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w_data   (w_data),
        .w_last   (w_last),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

    assign queue_full = fill.full;

endmodule

//--- test/axi_wr_slave.sv
module axi_wr_slave (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall_en,
    input  logic           aw_hold,
    input  logic           aw_valid,
    input  wb_pkg::paddr_t aw_addr,
    output logic           aw_ready,
    input  logic           w_valid,
    input  wb_pkg::beat_t  w_data,
    input  logic           w_last,
    output logic           w_ready,
    output logic           b_valid,
    input  logic           b_ready,
    output logic           line_done,
    output wb_pkg::paddr_t line_addr,
    output wb_pkg::line_t  line_data
);
    import wb_pkg::*;

    int   beat;
    logic done_now;
    logic b_done;
    logic rst_now;
    logic hold_now;
    logic stall_now;

    initial begin
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        line_done = 1'b0;
        beat      = 0;
    end

    // handshakes and controls are taken at the edge and the ready levels change just after it.
    always @(posedge clk) begin
        rst_now   = rst;
        hold_now  = aw_hold;
        stall_now = stall_en;
        done_now  = !rst && w_valid && w_ready && w_last;
        b_done    = !rst && b_valid && b_ready;
        if (!rst && aw_valid && aw_ready) begin
            line_addr = aw_addr;
            beat      = 0;
        end
        if (!rst && w_valid && w_ready) begin
            line_data[beat*BEAT_W +: BEAT_W] = w_data;
            beat++;
        end
        #1;
        line_done = done_now;
        b_valid   = done_now ? 1'b1 : (b_done ? 1'b0 : b_valid);    // one response per burst.
        aw_ready  = !rst_now && !hold_now && (!stall_now || $urandom_range(3) != 0);
        w_ready   = !rst_now && (!stall_now || $urandom_range(3) != 0);
    end

endmodule

//--- test/wb_tb.sv
module wb_tb;
    import wb_pkg::*;

    localparam int     ENTRIES    = 4;
    localparam int     MAX_CYCLES = 4000;
    localparam paddr_t NO_HIT     = 32'hffff_ffe0;    // never used as a line address.

    logic clk, rst, evict_valid, evict_ready, evict_dirty, lookup_hit, queue_full;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    logic stall_en, aw_hold, line_done, exp_hit, mdirty, add_now, rm_now, cur_dirty;
    paddr_t evict_addr, lookup_addr, aw_addr, line_addr;
    beat_t evict_data, w_data;
    line_t line_data;
    logic [7:0] aw_len;
    int errors, tests, failed, cycles, aw_count, line_id, mbeat, wbeat;
    line_addr_t exp_addr[$], pend[$], aw_order[$];
    line_t exp_data[$];
    line_addr_t mline, cur_line, add_line, rm_line;

    wb_top #(.ENTRIES(ENTRIES)) u_wb_top (.*);

    axi_wr_slave u_slave (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic log_error(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    // ************************************************************************
    // monitor, pending-line model and scoreboard.
    // ************************************************************************
    assign cur_dirty = (mbeat == 0) ? evict_dirty : mdirty;

    always @(posedge clk) begin
        if (rst) begin
            exp_hit = 1'b0;
            add_now = 1'b0;
            rm_now  = 1'b0;
            mbeat   = 0;
            wbeat   = 0;
        end else begin
            assert (lookup_hit === exp_hit) else log_error("lookup_hit differs from pending set");
            exp_hit = 1'b0;
            foreach (pend[i]) begin
                if (pend[i] == lookup_addr[PADDR_W-1:LINE_OFS_W]) exp_hit = 1'b1;
            end
            if (add_now) pend.push_back(add_line);    // slot valid one edge after last beat.
            if (rm_now) begin
                int ridx;
                ridx = -1;
                foreach (pend[i]) begin
                    if (pend[i] == rm_line) ridx = i;
                end
                if (ridx >= 0) pend.delete(ridx);
            end
            add_now = 1'b0;
            rm_now  = 1'b0;
            if (evict_valid && evict_ready) begin
                if (mbeat == 0) begin
                    mline  = evict_addr[PADDR_W-1:LINE_OFS_W];
                    mdirty = evict_dirty;
                end
                add_now  = (mbeat == BEATS - 1) && mdirty;
                add_line = mline;
                mbeat    = (mbeat == BEATS - 1) ? 0 : mbeat + 1;
            end
            if (aw_valid && aw_ready) begin
                aw_count++;
                cur_line = aw_addr[PADDR_W-1:LINE_OFS_W];
                aw_order.push_back(cur_line);
            end
            if (w_valid && w_ready) wbeat = w_last ? 0 : wbeat + 1;
            if (b_valid && b_ready) begin
                rm_now  = 1'b1;
                rm_line = cur_line;
            end
            if (line_done) begin
                int idx;
                idx = -1;
                foreach (exp_addr[i]) begin
                    if (exp_addr[i] == line_addr[PADDR_W-1:LINE_OFS_W]) idx = i;
                end
                assert (idx >= 0 && exp_data[idx] == line_data)
                    else log_error($sformatf("line %h written wrong", line_addr));
                if (idx >= 0) begin
                    exp_addr.delete(idx);
                    exp_data.delete(idx);
                end
            end
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else log_error("AW channel moved during a stall");
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
        else log_error("W channel moved during a stall");
    a_aw_fmt: assert property (@(posedge clk) disable iff (rst)
        aw_valid |-> aw_len == BEATS - 1 && aw_addr[LINE_OFS_W-1:0] == '0)
        else log_error("bad aw_len or unaligned aw_addr");
    a_w_last: assert property (@(posedge clk) disable iff (rst)
        w_valid |-> w_last == (wbeat == BEATS - 1))
        else log_error("w_last on the wrong beat");
    a_full_stall: assert property (@(posedge clk) disable iff (rst)
        evict_valid && evict_ready && mbeat == BEATS - 1 && cur_dirty |-> !queue_full)
        else log_error("last beat accepted while the queue was full");

    // ************************************************************************
    // stimulus.
    // ************************************************************************
    function automatic paddr_t new_addr();
        paddr_t a;
        a = $urandom();
        a[19:LINE_OFS_W] = 15'(line_id);
        a[LINE_OFS_W-1:0] = '0;
        line_id++;
        return a;
    endfunction

    task automatic send_line(input paddr_t addr, input logic dirty);
        line_t data;
        for (int b = 0; b < BEATS; b++) data[b*BEAT_W +: BEAT_W] = {$urandom(), $urandom()};
        if (dirty) begin
            exp_addr.push_back(addr[PADDR_W-1:LINE_OFS_W]);
            exp_data.push_back(data);
        end
        for (int b = 0; b < BEATS; b++) begin
            evict_valid = 1'b1;
            evict_addr  = addr + paddr_t'(b * BEAT_W / 8);
            evict_dirty = dirty;
            evict_data  = data[b*BEAT_W +: BEAT_W];
            @(posedge clk);
            while (!evict_ready) @(posedge clk);
            #1;
        end
        evict_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_addr.size() != 0 || pend.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) failed++;
        $display("test %s done, %0d new errors", name, errors - err_before);
    endtask

    initial begin
        paddr_t a[3];
        int e, base, ndirty;
        logic extra_done;
        void'($urandom(22));
        {rst, evict_valid, evict_dirty, aw_hold, stall_en} = 5'b10000;
        evict_addr  = '0;
        evict_data  = '0;
        lookup_addr = NO_HIT;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        e = errors;    // dirty lines under random ready stalls.
        stall_en = 1'b1;
        repeat (6) send_line(new_addr(), 1'b1);
        wait_drain();
        end_test("dirty_lines_and_backpressure", e);

        e = errors;
        base   = aw_count;
        ndirty = 0;
        for (int i = 0; i < 8; i++) begin
            evict_dirty = $urandom_range(1);
            ndirty += evict_dirty;
            send_line(new_addr(), evict_dirty);
        end
        wait_drain();
        assert (aw_count - base == ndirty) else log_error("AW count differs from dirty lines");
        end_test("clean_lines_dropped", e);

        e = errors;
        aw_hold = 1'b1;
        repeat (ENTRIES) send_line(new_addr(), 1'b1);
        repeat (2) @(posedge clk);
        #1;
        assert (queue_full)
            else log_error($sformatf("queue_full low after %0d queued lines", ENTRIES));
        extra_done = 1'b0;
        fork
            begin
                send_line(new_addr(), 1'b1);
                extra_done = 1'b1;
            end
            begin
                repeat (12) @(posedge clk);
                #1;
                assert (!extra_done)
                    else log_error("an eviction completed while the queue was full");
                aw_hold = 1'b0;
            end
        join
        wait_drain();
        end_test("full_queue_stall", e);

        e = errors;
        aw_hold = 1'b1;
        for (int i = 0; i < 3; i++) begin
            a[i] = new_addr();
            send_line(a[i], 1'b1);
        end
        for (int k = 0; k < 16; k++) begin
            lookup_addr = $urandom_range(1) ? a[$urandom_range(2)] + $urandom_range(31)
                                            : new_addr();
            @(posedge clk);
            #1;
        end
        lookup_addr = NO_HIT;
        aw_hold     = 1'b0;
        wait_drain();
        end_test("lookup", e);

        e = errors;    // slot 0 is presented and slot 2 is promoted over slot 1.
        aw_hold = 1'b1;
        base    = aw_order.size();
        for (int i = 0; i < 3; i++) begin
            a[i] = new_addr();
            send_line(a[i], 1'b1);
        end
        lookup_addr = a[2];
        repeat (3) @(posedge clk);
        #1 lookup_addr = NO_HIT;
        aw_hold = 1'b0;
        wait_drain();
        assert (aw_order.size() == base + 3 && aw_order[base] == a[0][PADDR_W-1:LINE_OFS_W]
                && aw_order[base+1] == a[2][PADDR_W-1:LINE_OFS_W]
                && aw_order[base+2] == a[1][PADDR_W-1:LINE_OFS_W])
            else log_error("promoted line did not drain next");
        end_test("promotion", e);

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/wb_pkg.sv
logic/wb_fill_if.sv
logic/wb_drain_if.sv
logic/victim_capture.sv
logic/replace_queue.sv
logic/axi_wb_writer.sv
logic/wb_top.sv
test/axi_wr_slave.sv
test/wb_tb.sv
